//--- lsq_pkg.sv
package lsq_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////

    // one data word and its byte lanes
    localparam int data_w = 32;
    localparam int strb_w = data_w / 8;

    // byte address bits above bit 1
    localparam int word_addr_w = 30;

    // dispatch, execute and retire width
    localparam int lanes = 3;

    // number of load lookup ports
    localparam int load_ports = 2;

    // largest queue index any build may use, modules take the low bits
    localparam int max_idx_w = 5;

    ////////////////////////////////////////
    // structs
    ////////////////////////////////////////

    // one store queue slot
    typedef struct packed {
        // address and data both known
        logic                   ready;
        logic [word_addr_w-1:0] addr;
        logic [strb_w-1:0]      usebytes;
        logic [data_w-1:0]      data;
    } sq_entry_t;

    // load request into the forward logic
    typedef struct packed {
        logic                   valid;
        // slot given at dispatch, stores from here on are younger
        logic [max_idx_w-1:0]   tail_pos;
        logic [word_addr_w-1:0] addr;
    } load_lookup_t;

    // answer for one load port
    typedef struct packed {
        // an older store has no address yet
        logic              stall;
        // bytes supplied by older stores
        logic [strb_w-1:0] usebytes;
        logic [data_w-1:0] data;
    } load_forward_t;

endpackage

//--- byte_priority.sv
module byte_priority #(
    parameter int width = 8
) (
    input  logic [width-1:0] req,
    output logic [width-1:0] gnt
);

    // highest index wins
    // scan upward and keep only the last hit
    always_comb begin
        gnt = '0;
        for (int i = 0; i < width; i++) begin
            if (req[i]) begin
                gnt    = '0;
                gnt[i] = 1'b1;
            end
        end
    end

endmodule

//--- store_queue.sv
module store_queue #(
    parameter int sq_idx_w = 3
) (
    input  logic                                    clock,
    input  logic                                    reset,
    // dispatch
    input  logic [lsq_pkg::lanes-1:0]               dispatch,
    output logic [lsq_pkg::lanes-1:0]               stall,
    output logic [lsq_pkg::lanes-1:0][sq_idx_w-1:0] tail_pos,
    // execute
    input  logic [lsq_pkg::lanes-1:0]               exe_valid,
    input  logic [lsq_pkg::lanes-1:0][sq_idx_w-1:0] exe_idx,
    input  lsq_pkg::sq_entry_t [lsq_pkg::lanes-1:0] exe_store,
    // retire and handoff to the drain
    input  logic [lsq_pkg::lanes-1:0]               retire,
    input  logic [1:0]                              retire_room,
    output lsq_pkg::sq_entry_t [lsq_pkg::lanes-1:0] cache_wb,
    output logic [1:0]                              wb_count,
    // queue view for the load ports
    output lsq_pkg::sq_entry_t [(1<<sq_idx_w)-1:0]  entries,
    output logic [sq_idx_w-1:0]                     head
);

    localparam int depth = 1 << sq_idx_w;

    // ring pointers and occupancy
    logic [sq_idx_w-1:0] tail;
    logic [sq_idx_w:0]   filled_count;
    logic [sq_idx_w:0]   free_slots;

    // per slot ready bits, payload kept apart
    logic [depth-1:0]   ready_q;
    logic [depth-1:0]   ready_next;
    lsq_pkg::sq_entry_t slot_q [depth];

    logic [1:0] dispatch_count;
    logic [1:0] retire_req;
    logic [1:0] retire_count;

    // head_idx[0] is the oldest slot
    logic [lsq_pkg::lanes-1:0][sq_idx_w-1:0] head_idx;

    assign dispatch_count = 2'($countones(dispatch));
    assign retire_req     = 2'($countones(retire));

    // never hand the drain more than it has room for
    assign retire_count = (retire_req > retire_room) ? retire_room : retire_req;
    assign wb_count     = retire_count;

    ////////////////////////////////////////
    // allocation
    ////////////////////////////////////////

    // free slots once this cycle's retirement is counted
    assign free_slots = (sq_idx_w+1)'(depth) - filled_count
                      + (sq_idx_w+1)'(retire_count);

    // one slot is always kept empty, so head == tail means empty
    always_comb begin
        if (free_slots < 2) begin
            stall = 3'b111;
        end else if (free_slots < 3) begin
            stall = 3'b011;
        end else if (free_slots < 4) begin
            stall = 3'b001;
        end else begin
            stall = 3'b000;
        end
    end

    // lane 2 is oldest and takes the tail slot
    always_comb begin
        tail_pos[2] = tail;
        tail_pos[1] = tail + sq_idx_w'(dispatch[2]);
        tail_pos[0] = tail + sq_idx_w'(dispatch[2]) + sq_idx_w'(dispatch[1]);
    end

    ////////////////////////////////////////
    // retire
    ////////////////////////////////////////

    always_comb begin
        for (int k = 0; k < lsq_pkg::lanes; k++) begin
            head_idx[k] = head + sq_idx_w'(k);
        end
    end

    // oldest retiring store goes out on lane 2
    always_comb begin
        cache_wb = '0;
        for (int k = 0; k < lsq_pkg::lanes; k++) begin
            if (k < retire_count) begin
                cache_wb[lsq_pkg::lanes-1-k] = entries[head_idx[k]];
            end
        end
    end

    // retired slots drop ready first, then executed slots set it
    always_comb begin
        ready_next = ready_q;
        for (int k = 0; k < lsq_pkg::lanes; k++) begin
            if (k < retire_count) begin
                ready_next[head_idx[k]] = 1'b0;
            end
        end
        for (int l = 0; l < lsq_pkg::lanes; l++) begin
            if (exe_valid[l]) begin
                ready_next[exe_idx[l]] = 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < depth; i++) begin
            entries[i]       = slot_q[i];
            entries[i].ready = ready_q[i];
        end
    end

    ////////////////////////////////////////
    // state
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            head         <= '0;
            tail         <= '0;
            filled_count <= '0;
            ready_q      <= '0;
        end else begin
            head         <= head + sq_idx_w'(retire_count);
            tail         <= tail + sq_idx_w'(dispatch_count);
            filled_count <= filled_count + (sq_idx_w+1)'(dispatch_count)
                          - (sq_idx_w+1)'(retire_count);
            ready_q      <= ready_next;
        end
    end

    // executed store payload
    always_ff @(posedge clock) begin
        for (int l = 0; l < lsq_pkg::lanes; l++) begin
            if (exe_valid[l]) begin
                slot_q[exe_idx[l]] <= exe_store[l];
            end
        end
    end

    // the spare slot keeps occupancy below the ring size
    assert property (@(posedge clock) disable iff (reset)
        filled_count < (sq_idx_w+1)'(depth));

    // execute only writes slots handed out at dispatch
    for (genvar l = 0; l < lsq_pkg::lanes; l++) begin : g_exe_check
        assert property (@(posedge clock) disable iff (reset)
            exe_valid[l] |-> (sq_idx_w'(exe_idx[l] - head) < filled_count));
    end

endmodule

//--- load_forward.sv
module load_forward #(
    parameter int sq_idx_w = 3
) (
    input  lsq_pkg::sq_entry_t [(1<<sq_idx_w)-1:0] entries,
    input  logic [sq_idx_w-1:0]                    head,
    input  lsq_pkg::load_lookup_t                  lookup,
    output lsq_pkg::load_forward_t                 result
);

    localparam int depth = 1 << sq_idx_w;

    logic [sq_idx_w-1:0] load_pos;
    logic [sq_idx_w-1:0] older_count;

    // rotated copy of the queue, youngest older store on top
    lsq_pkg::sq_entry_t [depth-1:0] window;
    logic [depth-1:0]               in_window;
    logic [depth-1:0]               pending;

    // per byte lane candidates and the chosen store
    logic [lsq_pkg::strb_w-1:0][depth-1:0] byte_req;
    logic [lsq_pkg::strb_w-1:0][depth-1:0] byte_gnt;

    assign load_pos = lookup.tail_pos[sq_idx_w-1:0];

    // stores from head up to the load's slot are older
    assign older_count = load_pos - head;

    ////////////////////////////////////////
    // older store window
    ////////////////////////////////////////

    // slot load_pos-1 lands on index depth-1
    always_comb begin
        for (int i = 0; i < depth; i++) begin
            window[i]    = entries[load_pos + sq_idx_w'(i)];
            in_window[i] = lookup.valid && (i + int'(older_count) >= depth);
            pending[i]   = in_window[i] && !window[i].ready;
        end
    end

    ////////////////////////////////////////
    // byte forwarding
    ////////////////////////////////////////

    always_comb begin
        for (int b = 0; b < lsq_pkg::strb_w; b++) begin
            for (int i = 0; i < depth; i++) begin
                byte_req[b][i] = in_window[i]
                               && window[i].ready
                               && (window[i].addr == lookup.addr)
                               && window[i].usebytes[b];
            end
        end
    end

    // youngest candidate per byte lane
    for (genvar b = 0; b < lsq_pkg::strb_w; b++) begin : g_byte_lane
        byte_priority #(
            .width(depth)
        ) u_pick (
            .req(byte_req[b]),
            .gnt(byte_gnt[b])
        );
    end

    always_comb begin
        result.stall = |pending;
        result.data  = '0;
        for (int b = 0; b < lsq_pkg::strb_w; b++) begin
            result.usebytes[b] = |byte_req[b];
            for (int i = 0; i < depth; i++) begin
                if (byte_gnt[b][i]) begin
                    result.data[8*b +: 8] = window[i].data[8*b +: 8];
                end
            end
        end
    end

endmodule

//--- store_drain_apb.sv
module store_drain_apb #(
    parameter int drain_depth = 4
) (
    input  logic                                    clock,
    input  logic                                    reset,
    // retired stores from the queue
    input  lsq_pkg::sq_entry_t [lsq_pkg::lanes-1:0] cache_wb,
    input  logic [1:0]                              wb_count,
    output logic [1:0]                              retire_room,
    // APB write master
    output logic                                    psel,
    output logic                                    penable,
    output logic                                    pwrite,
    output logic [31:0]                             paddr,
    output logic [lsq_pkg::data_w-1:0]              pwdata,
    output logic [lsq_pkg::strb_w-1:0]              pstrb,
    input  logic                                    pready
);

    localparam int ptr_w = $clog2(drain_depth);
    localparam int cnt_w = $clog2(drain_depth + 1);

    typedef enum logic [1:0] {
        drain_idle,
        drain_setup,
        drain_access
    } drain_state_t;

    drain_state_t       state;
    drain_state_t       state_next;
    lsq_pkg::sq_entry_t fifo_q [drain_depth];
    lsq_pkg::sq_entry_t head_store;
    logic [ptr_w-1:0]   rd_ptr;
    logic [ptr_w-1:0]   wr_ptr;
    logic [cnt_w-1:0]   fill_count;
    logic [cnt_w-1:0]   free_count;
    logic               pop;

    // pointer step with wrap for any depth
    function automatic logic [ptr_w-1:0] wrap_add(input logic [ptr_w-1:0] ptr, input int step);
        int sum;
        sum = int'(ptr) + step;
        if (sum >= drain_depth) begin
            sum = sum - drain_depth;
        end
        return ptr_w'(sum);
    endfunction

    ////////////////////////////////////////
    // write buffer
    ////////////////////////////////////////

    assign free_count  = cnt_w'(drain_depth) - fill_count;
    assign retire_room = (free_count >= 3) ? 2'd3 : 2'(free_count);

    // lane 2 holds the oldest store
    always_ff @(posedge clock) begin
        for (int k = 0; k < lsq_pkg::lanes; k++) begin
            if (k < wb_count) begin
                fifo_q[wrap_add(wr_ptr, k)] <= cache_wb[lsq_pkg::lanes-1-k];
            end
        end
    end

    ////////////////////////////////////////
    // bus side
    ////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            drain_idle: begin
                if (fill_count != 0) begin
                    state_next = drain_setup;
                end
            end
            drain_setup: begin
                state_next = drain_access;
            end
            drain_access: begin
                // straight into the next setup when more is queued
                if (pready) begin
                    state_next = (fill_count > 1) ? drain_setup : drain_idle;
                end
            end
            default: begin
                state_next = drain_idle;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= drain_idle;
            rd_ptr     <= '0;
            wr_ptr     <= '0;
            fill_count <= '0;
        end else begin
            state      <= state_next;
            rd_ptr     <= wrap_add(rd_ptr, int'(pop));
            wr_ptr     <= wrap_add(wr_ptr, int'(wb_count));
            fill_count <= fill_count + cnt_w'(wb_count) - cnt_w'(pop);
        end
    end

    // the transfer always carries the FIFO head
    assign head_store = fifo_q[rd_ptr];
    assign psel       = (state != drain_idle);
    assign penable    = (state == drain_access);
    assign pwrite     = 1'b1;
    assign paddr      = {head_store.addr, 2'b00};
    assign pwdata     = head_store.data;
    assign pstrb      = head_store.usebytes;
    assign pop        = penable && pready;

    // access phase only follows a selected cycle
    assert property (@(posedge clock) disable iff (reset)
        penable |-> psel && $past(psel));

    // head must not be overwritten while the slave is still working
    assert property (@(posedge clock) disable iff (reset)
        psel && !pop |=> $stable(paddr) && $stable(pwdata));

endmodule

//--- lsq_top.sv
module lsq_top #(
    parameter int sq_idx_w    = 3,
    parameter int drain_depth = 4
) (
    input  logic                                              clock,
    input  logic                                              reset,
    // dispatch
    input  logic [lsq_pkg::lanes-1:0]                         dispatch,
    output logic [lsq_pkg::lanes-1:0]                         stall,
    output logic [lsq_pkg::lanes-1:0][sq_idx_w-1:0]           tail_pos,
    // execute
    input  logic [lsq_pkg::lanes-1:0]                         exe_valid,
    input  logic [lsq_pkg::lanes-1:0][sq_idx_w-1:0]           exe_idx,
    input  lsq_pkg::sq_entry_t [lsq_pkg::lanes-1:0]           exe_store,
    // retire
    input  logic [lsq_pkg::lanes-1:0]                         retire,
    // load ports
    input  lsq_pkg::load_lookup_t [lsq_pkg::load_ports-1:0]   load_lookup,
    output lsq_pkg::load_forward_t [lsq_pkg::load_ports-1:0]  load_forward,
    // APB
    output logic                                              psel,
    output logic                                              penable,
    output logic                                              pwrite,
    output logic [31:0]                                       paddr,
    output logic [lsq_pkg::data_w-1:0]                        pwdata,
    output logic [lsq_pkg::strb_w-1:0]                        pstrb,
    input  logic                                              pready
);

    localparam int depth = 1 << sq_idx_w;

    lsq_pkg::sq_entry_t [depth-1:0]          entries;
    logic [sq_idx_w-1:0]                     head;
    lsq_pkg::sq_entry_t [lsq_pkg::lanes-1:0] cache_wb;
    logic [1:0]                              wb_count;
    logic [1:0]                              retire_room;

    store_queue #(
        .sq_idx_w(sq_idx_w)
    ) u_queue (
        .clock      (clock),
        .reset      (reset),
        .dispatch   (dispatch),
        .stall      (stall),
        .tail_pos   (tail_pos),
        .exe_valid  (exe_valid),
        .exe_idx    (exe_idx),
        .exe_store  (exe_store),
        .retire     (retire),
        .retire_room(retire_room),
        .cache_wb   (cache_wb),
        .wb_count   (wb_count),
        .entries    (entries),
        .head       (head)
    );

    // one lookup unit per load port
    for (genvar p = 0; p < lsq_pkg::load_ports; p++) begin : g_load_port
        load_forward #(
            .sq_idx_w(sq_idx_w)
        ) u_forward (
            .entries(entries),
            .head   (head),
            .lookup (load_lookup[p]),
            .result (load_forward[p])
        );
    end

    store_drain_apb #(
        .drain_depth(drain_depth)
    ) u_drain (
        .clock      (clock),
        .reset      (reset),
        .cache_wb   (cache_wb),
        .wb_count   (wb_count),
        .retire_room(retire_room),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .pstrb      (pstrb),
        .pready     (pready)
    );

endmodule

//--- tb_apb_memory.sv
module tb_apb_memory (
    input  logic        clock,
    input  logic        reset,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] paddr,
    input  logic [31:0] pwdata,
    input  logic [3:0]  pstrb,
    output logic        pready
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int words_n = 64;

    // word i starts with every byte equal to i
    logic [31:0] words [words_n];
    logic [1:0]  wait_left;

    initial begin
        void'($urandom(74));
        for (int i = 0; i < words_n; i++) begin
            words[i] = 32'h01010101 * 32'(i);
        end
    end

    // 0 to 3 wait states drawn in the setup cycle
    always @(posedge clock) begin
        if (reset) begin
            wait_left <= 2'd0;
        end else if (psel && !penable) begin
            wait_left <= 2'($urandom % 4);
        end else if (penable && wait_left != 2'd0) begin
            wait_left <= wait_left - 2'd1;
        end
    end

    assign pready = penable && (wait_left == 2'd0);

    // byte merge under pstrb at the end of the access
    always @(posedge clock) begin
        if (!reset && psel && penable && pready && pwrite) begin
            for (int b = 0; b < 4; b++) begin
                if (pstrb[b]) begin
                    words[paddr[7:2]][8*b +: 8] <= pwdata[8*b +: 8];
                end
            end
        end
    end

endmodule

//--- tb_lsq.sv
module tb_lsq;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int sq_idx_w    = 3;
    localparam int drain_depth = 4;
    localparam int rec_w       = 9;
    localparam int max_records = 64;

    typedef enum logic [3:0] {
        op_dispatch  = 4'd0,
        op_execute   = 4'd1,
        op_retire    = 4'd2,
        op_lookup    = 4'd3,
        op_check_mem = 4'd4
    } op_t;

    logic                                              clock = 1'b0;
    logic                                              reset;
    logic [lsq_pkg::lanes-1:0]                         dispatch;
    logic [lsq_pkg::lanes-1:0]                         stall;
    logic [lsq_pkg::lanes-1:0][sq_idx_w-1:0]           tail_pos;
    logic [lsq_pkg::lanes-1:0]                         exe_valid;
    logic [lsq_pkg::lanes-1:0][sq_idx_w-1:0]           exe_idx;
    lsq_pkg::sq_entry_t [lsq_pkg::lanes-1:0]           exe_store;
    logic [lsq_pkg::lanes-1:0]                         retire;
    lsq_pkg::load_lookup_t [lsq_pkg::load_ports-1:0]   load_lookup;
    lsq_pkg::load_forward_t [lsq_pkg::load_ports-1:0]  load_forward;
    logic                                              psel;
    logic                                              penable;
    logic                                              pwrite;
    logic [31:0]                                       paddr;
    logic [31:0]                                       pwdata;
    logic [3:0]                                        pstrb;
    logic                                              pready;

    // nine hex words per vector line
    logic [31:0] vectors [max_records*rec_w];
    int          record_count;
    int          error_count = 0;
    int          cycle_count = 0;
    int          cycle_limit = 1000;

    always #5 clock = ~clock;

    lsq_top #(
        .sq_idx_w   (sq_idx_w),
        .drain_depth(drain_depth)
    ) dut (
        .clock       (clock),
        .reset       (reset),
        .dispatch    (dispatch),
        .stall       (stall),
        .tail_pos    (tail_pos),
        .exe_valid   (exe_valid),
        .exe_idx     (exe_idx),
        .exe_store   (exe_store),
        .retire      (retire),
        .load_lookup (load_lookup),
        .load_forward(load_forward),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .pstrb       (pstrb),
        .pready      (pready)
    );

    tb_apb_memory u_mem (
        .clock  (clock),
        .reset  (reset),
        .psel   (psel),
        .penable(penable),
        .pwrite (pwrite),
        .paddr  (paddr),
        .pwdata (pwdata),
        .pstrb  (pstrb),
        .pready (pready)
    );

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    task automatic report_mismatch(input string signal_name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        error_count++;
        $display("[ERROR] %0t %s expected %h actual %h", $time, signal_name, expected, actual);
    endtask

    task automatic clear_inputs();
        dispatch    = '0;
        exe_valid   = '0;
        exe_idx     = '0;
        exe_store   = '0;
        retire      = '0;
        load_lookup = '0;
    endtask

    // only lanes in the mask are given a slot
    task automatic dispatch_stores(input int base);
        logic [2:0] mask;
        mask = vectors[base+1][2:0];
        @(negedge clock);
        clear_inputs();
        dispatch = mask;
        #1;
        if (stall !== vectors[base+2][2:0]) begin
            report_mismatch("stall", vectors[base+2], 32'(stall));
        end
        for (int k = 0; k < lsq_pkg::lanes; k++) begin
            if (mask[k] && tail_pos[k] !== vectors[base+5-k][sq_idx_w-1:0]) begin
                report_mismatch($sformatf("tail_pos[%0d]", k), vectors[base+5-k],
                                32'(tail_pos[k]));
            end
        end
    endtask

    task automatic execute_store(input int base);
        lsq_pkg::sq_entry_t store;
        int lane;
        lane           = int'(vectors[base+1][1:0]);
        store.ready    = 1'b1;
        store.addr     = vectors[base+3][lsq_pkg::word_addr_w-1:0];
        store.usebytes = vectors[base+4][3:0];
        store.data     = vectors[base+5];
        @(negedge clock);
        clear_inputs();
        exe_valid[lane] = 1'b1;
        exe_idx[lane]   = vectors[base+2][sq_idx_w-1:0];
        exe_store[lane] = store;
    endtask

    // retire lanes stay contiguous from lane 2 and never exceed the room
    task automatic retire_stores(input int count);
        int left;
        int room;
        int take;
        left = count;
        while (left > 0) begin
            @(negedge clock);
            clear_inputs();
            room = int'(dut.retire_room);
            take = (left < room) ? left : room;
            for (int k = 0; k < take; k++) begin
                retire[lsq_pkg::lanes-1-k] = 1'b1;
            end
            left = left - take;
        end
    endtask

    task automatic check_forward_port(input int p, input logic [31:0] exp_su,
                                      input logic [31:0] exp_data);
        lsq_pkg::load_forward_t got;
        logic [31:0] mask;
        got = load_forward[p];
        for (int b = 0; b < 4; b++) begin
            mask[8*b +: 8] = {8{exp_su[b]}};
        end
        if (got.stall !== exp_su[4]) begin
            report_mismatch($sformatf("load_forward[%0d].stall", p), 32'(exp_su[4]),
                            32'(got.stall));
        end
        // a stalled load replays, its bytes are not used
        if (!exp_su[4]) begin
            if (got.usebytes !== exp_su[3:0]) begin
                report_mismatch($sformatf("load_forward[%0d].usebytes", p), 32'(exp_su[3:0]),
                                32'(got.usebytes));
            end
            if ((got.data & mask) !== (exp_data & mask)) begin
                report_mismatch($sformatf("load_forward[%0d].data", p), exp_data & mask,
                                got.data & mask);
            end
        end
    endtask

    task automatic lookup_loads(input int base);
        lsq_pkg::load_lookup_t req;
        @(negedge clock);
        clear_inputs();
        for (int p = 0; p < lsq_pkg::load_ports; p++) begin
            req.valid      = vectors[base+1+4*p][8];
            req.tail_pos   = vectors[base+1+4*p][4:0];
            req.addr       = vectors[base+2+4*p][lsq_pkg::word_addr_w-1:0];
            load_lookup[p] = req;
        end
        #1;
        for (int p = 0; p < lsq_pkg::load_ports; p++) begin
            check_forward_port(p, vectors[base+3+4*p], vectors[base+4+4*p]);
        end
    endtask

    // two idle samples in a row mean the write buffer is empty
    task automatic wait_bus_idle();
        int quiet;
        quiet = 0;
        while (quiet < 2) begin
            @(negedge clock);
            clear_inputs();
            quiet = psel ? 0 : quiet + 1;
        end
    endtask

    task automatic check_memory_word(input int base);
        logic [5:0]  index;
        logic [31:0] got;
        index = vectors[base+1][5:0];
        wait_bus_idle();
        got = u_mem.words[index];
        if (got !== vectors[base+2]) begin
            report_mismatch($sformatf("mem[%h]", index), vectors[base+2], got);
        end
    endtask

    ////////////////////////////////////////
    // run
    ////////////////////////////////////////

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("vector lines: %0d, errors: %0d", record_count, error_count);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        int  base;
        op_t op;
        reset = 1'b1;
        clear_inputs();
        for (int i = 0; i < max_records * rec_w; i++) begin
            vectors[i] = 32'hffffffff;
        end
        $readmemh("lsq_vectors.txt", vectors);
        record_count = 0;
        while (record_count < max_records && vectors[record_count*rec_w] !== 32'hffffffff) begin
            record_count++;
        end
        cycle_limit = 20 * record_count + 200;
        if (record_count == 0) begin
            error_count++;
            $display("no vector lines were read from lsq_vectors.txt");
        end

        repeat (3) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        for (int r = 0; r < record_count; r++) begin
            base = r * rec_w;
            if (vectors[base] > 32'd4) begin
                error_count++;
                $display("vector line %0d has an unknown opcode %h", r, vectors[base]);
            end else begin
                op = op_t'(vectors[base][3:0]);
                case (op)
                    op_dispatch:  dispatch_stores(base);
                    op_execute:   execute_store(base);
                    op_retire:    retire_stores(int'(vectors[base+1][3:0]));
                    op_lookup:    lookup_loads(base);
                    op_check_mem: check_memory_word(base);
                    default:      error_count++;
                endcase
            end
        end
        @(negedge clock);
        clear_inputs();

        $display("vector lines: %0d, errors: %0d", record_count, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- lsq_vectors.txt
// op 0 dispatch: mask stall tail2 tail1 tail0 | op 1 execute: lane idx addr bytes data
// op 2 retire: count | op 3 lookup: vt0 addr0 su0 data0 vt1 addr1 su1 data1 | op 4: addr data
// vt = valid<<8 | tail_pos, su = stall<<4 | usebytes, unused columns are 0
0 7 0 0 1 2 0 0 0
0 7 0 3 4 5 0 0 0
0 4 3 6 7 7 0 0 0
0 0 7 7 7 7 0 0 0
1 0 0 10 f aabbccdd 0 0 0
1 1 1 10 3 00001122 0 0 0
1 2 2 20 f 12345678 0 0 0
1 0 3 10 4 00330000 0 0 0
1 1 5 10 3 00005555 0 0 0
1 2 6 30 1 000000ee 0 0 0
3 104 10 0f aa331122 102 10 0f aabb1122
3 106 10 10 00000000 103 20 0f 12345678
1 0 4 10 8 44000000 0 0 0
3 106 10 0f 44335555 105 10 0f 44331122
3 107 30 01 000000ee 102 20 00 00000000
3 101 10 0f aabbccdd 000 10 00 00000000
2 3 0 0 0 0 0 0 0
2 4 0 0 0 0 0 0 0
4 10 44335555 0 0 0 0 0 0
4 20 12345678 0 0 0 0 0 0
4 30 303030ee 0 0 0 0 0 0
4 11 11111111 0 0 0 0 0 0
// queue wraps from slot 7 to slot 0
0 7 0 7 0 1 0 0 0
0 4 0 2 3 3 0 0 0
1 0 7 08 f 77777777 0 0 0
1 1 0 08 2 00000800 0 0 0
1 2 1 08 1 000000a1 0 0 0
3 102 08 0f 777708a1 103 08 10 00000000
1 0 2 08 c dead0000 0 0 0
3 100 08 0f 77777777 103 08 0f dead08a1
3 107 08 00 00000000 101 08 0f 77770877
2 4 0 0 0 0 0 0 0
4 08 dead08a1 0 0 0 0 0 0
0 0 0 3 3 3 0 0 0

//--- src.f
lsq_pkg.sv
byte_priority.sv
store_queue.sv
load_forward.sv
store_drain_apb.sv
lsq_top.sv
tb_apb_memory.sv
tb_lsq.sv
